// ==== aes_core.f ====
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_key_mem.sv
source/aes_encipher_block.sv
source/aes_decipher_block.sv
source/aes_core.sv
verif/aes_core_tb.sv

// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - files:
      - source/aes_pkg.sv
      - source/aes_sbox.sv
      - source/aes_key_mem.sv
      - source/aes_encipher_block.sv
      - source/aes_decipher_block.sv
      - source/aes_core.sv
  - target: test
    files:
      - verif/aes_core_tb.sv

// ==== verif/aes_core_tb.sv ====
`timescale 1ns/1ps

module aes_core_tb;
    import aes_pkg::*;

    // fips-197 appendix c.1 and appendix b vectors.
    localparam block_t KEY_C1 = 128'h0001_0203_0405_0607_0809_0a0b_0c0d_0e0f;
    localparam block_t PT_C1  = 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff;
    localparam block_t CT_C1  = 128'h69c4_e0d8_6a7b_0430_d8cd_b780_70b4_c55a;
    localparam block_t KEY_B  = 128'h2b7e_1516_28ae_d2a6_abf7_1588_09cf_4f3c;
    localparam block_t PT_B   = 128'h3243_f6a8_885a_308d_3131_98a2_e037_0734;
    localparam block_t CT_B   = 128'h3925_841d_02dc_09fb_dc11_8597_196a_0b32;

    localparam int NUM_RANDOM = 8;
    localparam int ENC_REQS   = 2 + NUM_RANDOM;
    localparam int DEC_REQS   = 1 + NUM_RANDOM;
    localparam int TIMEOUT    = ENC_REQS * 60 + DEC_REQS * 30 + 130;  // per-request bounds plus margin.

    logic   clk_i = 1'b0;
    logic   rst_ni;
    logic   encdec_i;
    logic   on_i;
    block_t key_i;
    block_t block_i;
    logic   ready_o;
    block_t result_o;
    logic   result_valid_o;

    string  test_name = "reset";
    block_t last_result;
    logic   have_result = 1'b0;
    int     cycles = 0;
    integer seed = 32'hd51b_334f;

    aes_core aes_core_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .encdec_i       (encdec_i),
        .on_i           (on_i),
        .key_i          (key_i),
        .block_i        (block_i),
        .ready_o        (ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // one request, then wait for the result pulse while watching the busy phase.
    task automatic run_request(input logic enc, input block_t key, input block_t blk,
                               output block_t res);
        @(posedge clk_i);
        #1;
        encdec_i = enc;
        key_i    = key;
        block_i  = blk;
        on_i     = 1'b1;
        @(posedge clk_i);
        #1;
        on_i = 1'b0;
        @(negedge clk_i);
        while (!result_valid_o) begin
            check_bit({test_name, " ready_o while busy"}, 1'b0, ready_o);
            if (have_result) check_block({test_name, " result_o held"}, last_result, result_o);
            @(negedge clk_i);
        end
        res         = result_o;
        last_result = result_o;
        have_result = 1'b1;
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run still going after %0d cycles in %s", cycles, test_name);
            abort_run();
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) result_valid_o |=> !result_valid_o)
        else begin
            $display("[ERROR] %s: result_valid_o high for more than one cycle", test_name);
            abort_run();
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(ready_o) |-> result_valid_o)
        else begin
            $display("[ERROR] %s: ready_o rose without a result_valid_o pulse", test_name);
            abort_run();
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni) result_valid_o |-> ready_o)
        else begin
            $display("[ERROR] %s: expected ready_o 1 with result_valid_o, actual 0", test_name);
            abort_run();
        end

    initial begin
        block_t res;
        block_t ct;
        block_t rnd_key;
        block_t rnd_blk;
        rst_ni   = 1'b0;
        on_i     = 1'b0;
        encdec_i = 1'b0;
        key_i    = '0;
        block_i  = '0;
        repeat (2) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        test_name = "reset_idle";
        repeat (3) begin
            @(negedge clk_i);
            check_bit({test_name, " ready_o"}, 1'b1, ready_o);
            check_bit({test_name, " result_valid_o"}, 1'b0, result_valid_o);
        end

        test_name = "fips197_c1_enc";
        run_request(1'b1, KEY_C1, PT_C1, res);
        check_block(test_name, CT_C1, res);

        test_name = "fips197_c1_dec";
        run_request(1'b0, KEY_C1, CT_C1, res);
        check_block(test_name, PT_C1, res);

        test_name = "fips197_b_enc";  // new key, so the expansion must rerun.
        run_request(1'b1, KEY_B, PT_B, res);
        check_block(test_name, CT_B, res);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_key = {$random(seed), $random(seed), $random(seed), $random(seed)};
            rnd_blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
            test_name = $sformatf("random_%0d_enc", i);
            run_request(1'b1, rnd_key, rnd_blk, ct);
            test_name = $sformatf("random_%0d_roundtrip", i);
            run_request(1'b0, rnd_key, ct, res);
            check_block(test_name, rnd_blk, res);
        end

        repeat (3) @(posedge clk_i);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== source/aes_core.sv ====
`timescale 1ns/1ps

module aes_core (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            encdec_i,
    input  logic            on_i,
    input  aes_pkg::block_t key_i,
    input  aes_pkg::block_t block_i,
    output logic            ready_o,
    output aes_pkg::block_t result_o,
    output logic            result_valid_o
);
    import aes_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        ready_q;
    logic        set_ready;
    logic        clr_ready;
    logic        valid_q;
    logic        valid_d;
    logic        next_q;
    logic        next_d;
    block_t      result_q;

    logic        key_init;
    logic        keymem_sel;
    block_t      round_key;
    logic        key_ready;
    word_t       keymem_sbox;
    word_t       enc_sbox;
    word_t       sbox_in;
    word_t       sbox_out;

    logic        enc_next;
    logic        dec_next;
    round_t      enc_round;
    round_t      dec_round;
    round_t      muxed_round;
    block_t      enc_block;
    block_t      dec_block;
    block_t      muxed_block;
    logic        enc_ready;
    logic        dec_ready;
    logic        muxed_ready;

    assign key_init   = on_i & ready_q;   // requests while busy are dropped.
    assign keymem_sel = (state_q == CTRL_INIT) || key_init;
    assign sbox_in    = keymem_sel ? keymem_sbox : enc_sbox;

    assign enc_next    = next_q & encdec_i;
    assign dec_next    = next_q & ~encdec_i;
    assign muxed_round = encdec_i ? enc_round : dec_round;
    assign muxed_block = encdec_i ? enc_block : dec_block;
    assign muxed_ready = encdec_i ? enc_ready : dec_ready;

    aes_key_mem key_mem (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .init_i      (key_init),
        .key_i       (key_i),
        .round_i     (muxed_round),
        .round_key_o (round_key),
        .ready_o     (key_ready),
        .sbox_o      (keymem_sbox),
        .sbox_i      (sbox_out)
    );

    aes_encipher_block enc_block_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .next_i      (enc_next),
        .round_key_i (round_key),
        .block_i     (block_i),
        .round_o     (enc_round),
        .sbox_o      (enc_sbox),
        .sbox_i      (sbox_out),
        .new_block_o (enc_block),
        .ready_o     (enc_ready)
    );

    aes_decipher_block dec_block_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .next_i      (dec_next),
        .round_key_i (round_key),
        .block_i     (block_i),
        .round_o     (dec_round),
        .new_block_o (dec_block),
        .ready_o     (dec_ready)
    );

    aes_sbox #(
        .INVERSE (1'b0)
    ) sbox_inst (
        .in_i  (sbox_in),
        .out_o (sbox_out)
    );

    always_comb begin
        state_d   = state_q;
        next_d    = 1'b0;
        set_ready = 1'b0;
        clr_ready = 1'b0;
        valid_d   = 1'b0;
        case (state_q)
            CTRL_IDLE: begin
                if (key_init) begin
                    state_d   = CTRL_INIT;
                    clr_ready = 1'b1;
                end else if (next_q) begin
                    state_d = CTRL_NEXT;   // engine starts on this same edge.
                end
            end
            CTRL_INIT: begin
                if (key_ready) begin
                    state_d = CTRL_IDLE;
                    next_d  = 1'b1;
                end
            end
            CTRL_NEXT: begin
                if (muxed_ready) begin
                    state_d   = CTRL_IDLE;
                    set_ready = 1'b1;
                    valid_d   = 1'b1;
                end
            end
            default: state_d = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= CTRL_IDLE;
            ready_q <= 1'b1;
            valid_q <= 1'b0;
            next_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= valid_d;
            next_q  <= next_d;
            if (clr_ready) ready_q <= 1'b0;
            else if (set_ready) ready_q <= 1'b1;
        end
    end

    // result stays put until the next request finishes.
    always_ff @(posedge clk_i) begin
        if (valid_d) result_q <= muxed_block;
    end

    assign ready_o        = ready_q;
    assign result_o       = result_q;
    assign result_valid_o = valid_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni) on_i |-> ready_q)
        else $error("on_i while the core is busy, request ignored");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |-> $rose(ready_o) ##1 !result_valid_o)
        else $error("result_valid_o not a single pulse aligned with ready_o");

endmodule

// ==== source/aes_decipher_block.sv ====
`timescale 1ns/1ps

module aes_decipher_block (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            next_i,
    input  aes_pkg::block_t round_key_i,
    input  aes_pkg::block_t block_i,
    output aes_pkg::round_t round_o,
    output aes_pkg::block_t new_block_o,
    output logic            ready_o
);
    import aes_pkg::*;

    typedef enum logic {
        DEC_IDLE,
        DEC_ROUND
    } dec_state_e;

    dec_state_e state_q;
    round_t     round_q;   // rests at the last round key while idle.
    logic       ready_q;
    block_t     block_q;
    block_t     rows;
    block_t     subbed;
    block_t     keyed;
    block_t     round_out;

    assign rows = inv_shift_rows(block_q);

    for (genvar i = 0; i < 4; i++) begin : g_inv_sbox
        aes_sbox #(
            .INVERSE (1'b1)
        ) sbox_inst (
            .in_i  (rows[127 - 32*i -: 32]),
            .out_o (subbed[127 - 32*i -: 32])
        );
    end

    assign keyed     = subbed ^ round_key_i;
    assign round_out = (round_q == '0) ? keyed : inv_mix_columns(keyed);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= DEC_IDLE;
            ready_q <= 1'b1;
            round_q <= round_t'(NUM_ROUNDS);
        end else begin
            case (state_q)
                DEC_IDLE: begin
                    if (next_i) begin
                        state_q <= DEC_ROUND;
                        ready_q <= 1'b0;
                        round_q <= round_t'(NUM_ROUNDS - 1);
                    end
                end
                DEC_ROUND: begin
                    if (round_q == '0) begin
                        state_q <= DEC_IDLE;
                        ready_q <= 1'b1;
                        round_q <= round_t'(NUM_ROUNDS);
                    end else begin
                        round_q <= round_q - round_t'(1);
                    end
                end
                default: state_q <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DEC_IDLE && next_i) begin
            block_q <= block_i ^ round_key_i;   // initial add with round key 10.
        end else if (state_q == DEC_ROUND) begin
            block_q <= round_out;
        end
    end

    assign round_o     = round_q;
    assign new_block_o = block_q;
    assign ready_o     = ready_q;

endmodule

// ==== source/aes_encipher_block.sv ====
`timescale 1ns/1ps

module aes_encipher_block (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            next_i,
    input  aes_pkg::block_t round_key_i,
    input  aes_pkg::block_t block_i,
    output aes_pkg::round_t round_o,
    output aes_pkg::word_t  sbox_o,
    input  aes_pkg::word_t  sbox_i,
    output aes_pkg::block_t new_block_o,
    output logic            ready_o
);
    import aes_pkg::*;

    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_INIT,
        ENC_SUB
    } enc_state_e;

    enc_state_e state_q;
    round_t     round_q;
    logic [1:0] word_q;     // column going through the s-box.
    logic       ready_q;
    block_t     block_q;
    block_t     sub_block;
    block_t     linear;
    block_t     round_out;

    assign sbox_o = block_q[127 - 32*word_q -: 32];

    always_comb begin
        sub_block = block_q;
        sub_block[127 - 32*word_q -: 32] = sbox_i;
        linear = shift_rows(sub_block);
        if (round_q != NUM_ROUNDS) linear = mix_columns(linear);  // final round has none.
        round_out = linear ^ round_key_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ENC_IDLE;
            ready_q <= 1'b1;
            round_q <= '0;
            word_q  <= '0;
        end else begin
            case (state_q)
                ENC_IDLE: begin
                    if (next_i) begin
                        state_q <= ENC_INIT;
                        ready_q <= 1'b0;
                        round_q <= '0;
                    end
                end
                ENC_INIT: begin
                    state_q <= ENC_SUB;
                    round_q <= round_t'(1);
                    word_q  <= '0;
                end
                ENC_SUB: begin
                    word_q <= word_q + 2'd1;
                    if (word_q == 2'd3) begin
                        if (round_q == NUM_ROUNDS) begin
                            state_q <= ENC_IDLE;
                            ready_q <= 1'b1;
                        end else begin
                            round_q <= round_q + round_t'(1);
                        end
                    end
                end
                default: state_q <= ENC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ENC_INIT) begin
            block_q <= block_i ^ round_key_i;
        end else if (state_q == ENC_SUB) begin
            block_q <= (word_q == 2'd3) ? round_out : sub_block;
        end
    end

    assign round_o     = round_q;
    assign new_block_o = block_q;
    assign ready_o     = ready_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni) round_o <= NUM_ROUNDS)
        else $error("encipher round index out of range");

endmodule

// ==== source/aes_key_mem.sv ====
`timescale 1ns/1ps

module aes_key_mem (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            init_i,
    input  aes_pkg::block_t key_i,
    input  aes_pkg::round_t round_i,
    output aes_pkg::block_t round_key_o,
    output logic            ready_o,
    output aes_pkg::word_t  sbox_o,
    input  aes_pkg::word_t  sbox_i
);
    import aes_pkg::*;

    block_t     rk_q [0:NUM_ROUNDS];
    block_t     prev_key_q;
    block_t     next_key;
    logic [7:0] rcon_q;
    round_t     round_ctr_q;   // zero while idle.
    logic       ready_q;
    word_t      w0;
    word_t      w1;
    word_t      w2;
    word_t      w3;

    // rotword goes before subword, the two commute.
    assign sbox_o = {prev_key_q[23:0], prev_key_q[31:24]};

    assign w0       = prev_key_q[127:96] ^ sbox_i ^ {rcon_q, 24'h0};
    assign w1       = prev_key_q[95:64] ^ w0;
    assign w2       = prev_key_q[63:32] ^ w1;
    assign w3       = prev_key_q[31:0] ^ w2;
    assign next_key = {w0, w1, w2, w3};

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            round_ctr_q <= '0;
            ready_q     <= 1'b0;
        end else if (init_i) begin
            round_ctr_q <= round_t'(1);
            ready_q     <= 1'b0;
        end else if (round_ctr_q != '0) begin
            if (round_ctr_q == NUM_ROUNDS) begin
                round_ctr_q <= '0;
                ready_q     <= 1'b1;   // last round key written.
            end else begin
                round_ctr_q <= round_ctr_q + round_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (init_i) begin
            rk_q[0]    <= key_i;
            prev_key_q <= key_i;
            rcon_q     <= 8'h01;
        end else if (round_ctr_q != '0) begin
            rk_q[round_ctr_q] <= next_key;
            prev_key_q        <= next_key;
            rcon_q            <= xtime(rcon_q);
        end
    end

    assign round_key_o = rk_q[round_i];
    assign ready_o     = ready_q;

    // the core only accepts a request while idle, so expansion is never restarted.
    assert property (@(posedge clk_i) disable iff (!rst_ni) init_i |-> round_ctr_q == '0)
        else $error("key expansion restarted while running");

endmodule

// ==== source/aes_sbox.sv ====
`timescale 1ns/1ps

module aes_sbox #(
    parameter bit INVERSE = 1'b0
) (
    input  aes_pkg::word_t in_i,
    output aes_pkg::word_t out_o
);
    import aes_pkg::*;

    function automatic logic [7:0] rotl(logic [7:0] b, int unsigned n);
        return (b << n) | (b >> (8 - n));
    endfunction

    function automatic logic [7:0] affine(logic [7:0] b);
        return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ SBOX_AFFINE_C;
    endfunction

    function automatic logic [7:0] inv_affine(logic [7:0] b);
        return rotl(b, 1) ^ rotl(b, 3) ^ rotl(b, 6) ^ SBOX_INV_AFFINE_C;
    endfunction

    for (genvar i = 0; i < 4; i++) begin : g_byte
        logic [7:0] b;

        assign b = in_i[8*i +: 8];

        if (INVERSE) begin : g_inv
            assign out_o[8*i +: 8] = gf_inv(inv_affine(b)); // undo the affine map first.
        end else begin : g_fwd
            assign out_o[8*i +: 8] = affine(gf_inv(b));
        end
    end

endmodule

// ==== source/aes_pkg.sv ====
package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   round_t;

    localparam int NUM_ROUNDS = 10;

    localparam word_t       MIX_COEF          = 32'h0203_0101;
    localparam word_t       INV_MIX_COEF      = 32'h0e0b_0d09;
    localparam logic [7:0]  SBOX_AFFINE_C     = 8'h63;
    localparam logic [7:0]  SBOX_INV_AFFINE_C = 8'h05;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_INIT,
        CTRL_NEXT
    } ctrl_state_e;

    // multiply by x modulo the aes polynomial.
    function automatic logic [7:0] xtime(logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] x;
        acc = 8'h00;
        x   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc ^= x;
            x = xtime(x);
        end
        return acc;
    endfunction

    // a^254, which is the inverse for nonzero a and maps 0 to 0.
    function automatic logic [7:0] gf_inv(logic [7:0] a);
        logic [7:0] p;
        logic [7:0] r;
        p = a;
        r = 8'h01;
        for (int i = 0; i < 7; i++) begin
            p = gf_mul(p, p);
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    // state byte (row r, column c) sits at block bits 127-8*(4c+r).
    function automatic block_t shift_rows(block_t b);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[127 - 8*(4*c + r) -: 8] = b[127 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
        return o;
    endfunction

    function automatic block_t inv_shift_rows(block_t b);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[127 - 8*(4*c + r) -: 8] = b[127 - 8*(4*((c - r + 4) % 4) + r) -: 8];
            end
        end
        return o;
    endfunction

    // circulant matrix product on one column, first row of coefficients in coef.
    function automatic word_t mix_word(word_t w, word_t coef);
        word_t o;
        o = '0;
        for (int r = 0; r < 4; r++) begin
            for (int j = 0; j < 4; j++) begin
                o[31 - 8*r -: 8] ^= gf_mul(coef[31 - 8*((j - r + 4) % 4) -: 8], w[31 - 8*j -: 8]);
            end
        end
        return o;
    endfunction

    function automatic block_t mix_columns(block_t b);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            o[127 - 32*c -: 32] = mix_word(b[127 - 32*c -: 32], MIX_COEF);
        end
        return o;
    endfunction

    function automatic block_t inv_mix_columns(block_t b);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            o[127 - 32*c -: 32] = mix_word(b[127 - 32*c -: 32], INV_MIX_COEF);
        end
        return o;
    endfunction

endpackage
